//--- design/ccip_shim_pkg.sv
/*
 * Shared types and constants for the single-clock AFU behind the platform shim.
 * Receive header is one 12-bit word, read as MMIO or memory response view.
 * The receive kind selects which view of the header is meaningful.
 * Only CSR indices 0 to 7 exist even though the index field is 4 bits.
 */

package ccip_shim_pkg;

    // ==================================================
    // Widths and constants
    // ==================================================
    localparam int CSR_IDX_W = 4;
    localparam int TID_W     = 8;
    localparam int MDATA_W   = 10;
    localparam int DATA_W    = 64;

    // Returned by a read of CSR 0
    localparam logic [DATA_W-1:0] AFU_ID = 64'h5a1c_0f3e_b41f_7c0e;

    // ==================================================
    // Receive channel
    // ==================================================
    typedef enum logic [1:0] {
        RX_NONE    = 2'd0,
        RX_MMIO_WR = 2'd1,
        RX_MMIO_RD = 2'd2,
        RX_MEM_RSP = 2'd3
    } t_rx_kind;

    // MMIO view of the header
    typedef struct packed {
        logic [TID_W-1:0]     tid;
        logic [CSR_IDX_W-1:0] csr_idx;
    } t_mmio_hdr;

    // Memory response view, cl_num 0 means a single line
    typedef struct packed {
        logic [MDATA_W-1:0] mdata;
        logic [1:0]         cl_num;
    } t_mem_rsp_hdr;

    typedef union packed {
        t_mmio_hdr    mmio;
        t_mem_rsp_hdr mem_rsp;
    } t_rx_hdr_u;

    typedef struct packed {
        logic              valid;
        t_rx_kind          kind;
        t_rx_hdr_u         hdr;
        logic [DATA_W-1:0] data;
    } t_if_rx;

    // Transmit channel, MMIO read responses only
    typedef struct packed {
        logic              valid;
        logic [TID_W-1:0]  tid;
        logic [DATA_W-1:0] data;
    } t_if_tx;

    // ==================================================
    // Internal stage interfaces
    // ==================================================
    typedef enum logic [1:0] {
        OP_CSR_WR = 2'd0,
        OP_CSR_RD = 2'd1,
        OP_ACCUM  = 2'd2
    } t_exec_op_kind;

    typedef struct packed {
        logic                 valid;
        t_exec_op_kind        op;
        logic [CSR_IDX_W-1:0] idx;
        logic [TID_W-1:0]     tid;
        logic [DATA_W-1:0]    data;
    } t_exec_op;

    typedef struct packed {
        logic              valid;
        logic [TID_W-1:0]  tid;
        logic [DATA_W-1:0] data;
    } t_rd_rsp;

endpackage

//--- design/platform_shim.sv
/*
 * Timing register stages between the FIU side and the AFU side.
 * Each path (rx, tx, credit return) is delayed by exactly N_REG_STAGES cycles.
 * N_REG_STAGES of 0 gives plain wires. No clock crossing, pClk only.
 * Credits in flight must cover the added round trip on the AFU side.
 */

module platform_shim #(
    parameter int N_REG_STAGES = 1
) (
    input  logic                  pClk,
    input  logic                  rst_n,

    // FIU side
    input  ccip_shim_pkg::t_if_rx fiu_rx,
    output ccip_shim_pkg::t_if_tx fiu_tx,
    input  logic                  fiu_credit_return,

    // AFU side
    output ccip_shim_pkg::t_if_rx afu_rx,
    input  ccip_shim_pkg::t_if_tx afu_tx,
    output logic                  afu_credit_return
);
    import ccip_shim_pkg::*;

    generate
        if (N_REG_STAGES == 0)
        begin : g_wire
            // Straight through
            assign afu_rx            = fiu_rx;
            assign fiu_tx            = afu_tx;
            assign afu_credit_return = fiu_credit_return;
        end
        else
        begin : g_reg
            // Valid bits carry reset, payload does not
            logic   rx_vld_q [N_REG_STAGES];
            logic   tx_vld_q [N_REG_STAGES];
            logic   cr_q     [N_REG_STAGES];
            t_if_rx rx_q     [N_REG_STAGES];
            t_if_tx tx_q     [N_REG_STAGES];

            for (genvar i = 0; i < N_REG_STAGES; i++)
            begin : g_stage
                t_if_rx rx_d;
                t_if_tx tx_d;
                logic   cr_d;

                // Stage 0 takes the ports, later stages the previous stage
                if (i == 0)
                begin : g_src
                    assign rx_d = fiu_rx;
                    assign tx_d = afu_tx;
                    assign cr_d = fiu_credit_return;
                end
                else
                begin : g_src
                    assign rx_d = '{valid: rx_vld_q[i-1], kind: rx_q[i-1].kind,
                                    hdr: rx_q[i-1].hdr, data: rx_q[i-1].data};
                    assign tx_d = '{valid: tx_vld_q[i-1], tid: tx_q[i-1].tid,
                                    data: tx_q[i-1].data};
                    assign cr_d = cr_q[i-1];
                end

                always_ff @(posedge pClk or negedge rst_n)
                begin
                    if (!rst_n)
                    begin
                        rx_vld_q[i] <= 1'b0;
                        tx_vld_q[i] <= 1'b0;
                        cr_q[i]     <= 1'b0;
                    end
                    else
                    begin
                        rx_vld_q[i] <= rx_d.valid;
                        tx_vld_q[i] <= tx_d.valid;
                        cr_q[i]     <= cr_d;
                    end
                end

                // Payload follows its valid bit
                always_ff @(posedge pClk)
                begin
                    rx_q[i] <= rx_d;
                    tx_q[i] <= tx_d;
                end
            end

            // Last stage drives the far side
            always_comb
            begin
                afu_rx       = rx_q[N_REG_STAGES-1];
                afu_rx.valid = rx_vld_q[N_REG_STAGES-1];
                fiu_tx       = tx_q[N_REG_STAGES-1];
                fiu_tx.valid = tx_vld_q[N_REG_STAGES-1];
            end
            assign afu_credit_return = cr_q[N_REG_STAGES-1];
        end
    endgenerate

endmodule

//--- design/afu_rx_decode.sv
/*
 * Registered classifier for receive messages, one cycle of latency.
 * MMIO and memory response headers share one word, read by message kind.
 * Memory responses with cl_num other than 0 are dropped silently.
 */

module afu_rx_decode (
    input  logic                    pClk,
    input  logic                    rst_n,
    input  ccip_shim_pkg::t_if_rx   rx,
    output ccip_shim_pkg::t_exec_op op
);
    import ccip_shim_pkg::*;

    t_mmio_hdr    mmio_h;
    t_mem_rsp_hdr mem_h;
    t_exec_op     op_d;
    logic         op_vld_q;
    t_exec_op     op_q;

    // Both views of the same header word
    assign mmio_h = rx.hdr.mmio;
    assign mem_h  = rx.hdr.mem_rsp;

    always_comb
    begin
        op_d      = '0;
        op_d.data = rx.data;
        case (rx.kind)
            RX_MMIO_WR:
            begin
                op_d.valid = rx.valid;
                op_d.op    = OP_CSR_WR;
                op_d.idx   = mmio_h.csr_idx;
                op_d.tid   = mmio_h.tid;
            end
            RX_MMIO_RD:
            begin
                op_d.valid = rx.valid;
                op_d.op    = OP_CSR_RD;
                op_d.idx   = mmio_h.csr_idx;
                op_d.tid   = mmio_h.tid;
            end
            RX_MEM_RSP:
            begin
                // Single-line responses only
                op_d.valid = rx.valid && (mem_h.cl_num == 2'd0);
                op_d.op    = OP_ACCUM;
            end
            default:
            begin
                op_d.valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
            op_vld_q <= 1'b0;
        else
            op_vld_q <= op_d.valid;
    end

    // Operation payload, no reset
    always_ff @(posedge pClk)
    begin
        op_q <= op_d;
    end

    always_comb
    begin
        op       = op_q;
        op.valid = op_vld_q;
    end

    // Host must never flag a message without a kind
    a_no_kind_none: assert property (@(posedge pClk) disable iff (!rst_n)
        rx.valid |-> (rx.kind != RX_NONE));

endmodule

//--- design/afu_csr_exec.sv
/*
 * CSR file and memory response accumulator, one cycle per operation.
 * Map: 0 AFU_ID (RO), 1 scratch, 2 accumulator, 3 response count (RO),
 * 4 to 7 scratch. Indices 8 and up read as 0 and ignore writes.
 * A read sees the CSR value from before any write in the same cycle.
 */

module afu_csr_exec (
    input  logic                    pClk,
    input  logic                    rst_n,
    input  ccip_shim_pkg::t_exec_op op,
    output ccip_shim_pkg::t_rd_rsp  rsp
);
    import ccip_shim_pkg::*;

    // ==================================================
    // CSR storage
    // ==================================================
    logic [DATA_W-1:0] scratch1_q;
    logic [DATA_W-1:0] scratch_hi_q [4];
    logic [DATA_W-1:0] accum_q;
    logic [DATA_W-1:0] mem_cnt_q;

    logic [DATA_W-1:0] rd_val;
    logic              rsp_vld_q;
    logic [TID_W-1:0]  rsp_tid_q;
    logic [DATA_W-1:0] rsp_data_q;

    // Read mux over the current register values
    always_comb
    begin
        case (op.idx)
            4'd0:    rd_val = AFU_ID;
            4'd1:    rd_val = scratch1_q;
            4'd2:    rd_val = accum_q;
            4'd3:    rd_val = mem_cnt_q;
            4'd4, 4'd5, 4'd6, 4'd7:
                     rd_val = scratch_hi_q[op.idx[1:0]];
            default: rd_val = '0;
        endcase
    end

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scratch1_q   <= '0;
            scratch_hi_q <= '{default: '0};
            accum_q      <= '0;
            mem_cnt_q    <= '0;
        end
        else if (op.valid)
        begin
            if (op.op == OP_ACCUM)
            begin
                // Wraps at 64 bits
                accum_q   <= accum_q + op.data;
                mem_cnt_q <= mem_cnt_q + 1'b1;
            end
            else if (op.op == OP_CSR_WR)
            begin
                case (op.idx)
                    4'd1:    scratch1_q <= op.data;
                    4'd2:    accum_q    <= op.data;
                    4'd4, 4'd5, 4'd6, 4'd7:
                             scratch_hi_q[op.idx[1:0]] <= op.data;
                    default: ; // 0, 3 and unimplemented indices are read only
                endcase
            end
        end
    end

    // ==================================================
    // Read response
    // ==================================================
    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
            rsp_vld_q <= 1'b0;
        else
            rsp_vld_q <= op.valid && (op.op == OP_CSR_RD);
    end

    always_ff @(posedge pClk)
    begin
        rsp_tid_q  <= op.tid;
        rsp_data_q <= rd_val;
    end

    assign rsp = '{valid: rsp_vld_q, tid: rsp_tid_q, data: rsp_data_q};

    // An undefined operation code would be dropped here without a response
    a_op_legal: assert property (@(posedge pClk) disable iff (!rst_n)
        op.valid |-> (op.op inside {OP_CSR_WR, OP_CSR_RD, OP_ACCUM}));

endmodule

//--- design/afu_tx_result.sv
/*
 * Read response queue and transmit driver with credit flow control.
 * Counter starts at TX_CREDITS, gains one per credit_return, loses one per send.
 * An empty queue lets a response go straight to the transmit register.
 * Host must keep at most RSP_DEPTH reads outstanding, the queue has no stall.
 */

module afu_tx_result #(
    parameter int TX_CREDITS = 4,
    parameter int RSP_DEPTH  = 4
) (
    input  logic                   pClk,
    input  logic                   rst_n,
    input  ccip_shim_pkg::t_rd_rsp rsp,
    input  logic                   credit_return,
    output ccip_shim_pkg::t_if_tx  tx
);
    import ccip_shim_pkg::*;

    localparam int PTR_W  = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
    localparam int CNT_W  = $clog2(RSP_DEPTH + 1);
    localparam int CRED_W = $clog2(TX_CREDITS + 1);

    t_rd_rsp           fifo_mem [RSP_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic [CRED_W-1:0] credit_q;

    logic              fifo_empty;
    logic              send;
    logic              push;
    logic              pop;
    t_rd_rsp           send_rsp;

    logic              tx_vld_q;
    logic [TID_W-1:0]  tx_tid_q;
    logic [DATA_W-1:0] tx_data_q;

    // ==================================================
    // Send decision
    // ==================================================
    assign fifo_empty = (count_q == '0);
    assign send       = (credit_q != '0) && (!fifo_empty || rsp.valid);
    assign pop        = send && !fifo_empty;
    // Bypass the queue when it is empty and a credit is free
    assign push       = rsp.valid && !(send && fifo_empty);
    assign send_rsp   = fifo_empty ? rsp : fifo_mem[rd_ptr_q];

    always_ff @(posedge pClk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= CRED_W'(TX_CREDITS);
            tx_vld_q <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr_q <= (wr_ptr_q == PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= (rd_ptr_q == PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            count_q  <= count_q + CNT_W'(push) - CNT_W'(pop);
            // Returns and sends in the same cycle cancel
            credit_q <= credit_q + CRED_W'(credit_return) - CRED_W'(send);
            tx_vld_q <= send;
        end
    end

    // Queue storage and transmit payload
    always_ff @(posedge pClk)
    begin
        if (push)
            fifo_mem[wr_ptr_q] <= rsp;
        if (send)
        begin
            tx_tid_q  <= send_rsp.tid;
            tx_data_q <= send_rsp.data;
        end
    end

    assign tx = '{valid: tx_vld_q, tid: tx_tid_q, data: tx_data_q};

    // Host exceeded its outstanding read limit
    a_no_overflow: assert property (@(posedge pClk) disable iff (!rst_n)
        push |-> ((count_q < CNT_W'(RSP_DEPTH)) || pop));

    // Host returned more credits than it was given
    a_credit_max: assert property (@(posedge pClk) disable iff (!rst_n)
        credit_q <= CRED_W'(TX_CREDITS));

endmodule

//--- design/afu_top.sv
/*
 * AFU top level behind the platform shim, single clock pClk.
 * MMIO read latency is 2*N_REG_STAGES + 3 cycles with an empty queue and a credit.
 * Host keeps at most RSP_DEPTH reads outstanding and owns TX_CREDITS buffer slots.
 */

module afu_top #(
    parameter int N_REG_STAGES = 1,
    parameter int TX_CREDITS   = 4,
    parameter int RSP_DEPTH    = 4
) (
    input  logic                  pClk,
    input  logic                  rst_n,
    input  ccip_shim_pkg::t_if_rx host_rx,
    output ccip_shim_pkg::t_if_tx host_tx,
    input  logic                  host_credit_return
);
    import ccip_shim_pkg::*;

    t_if_rx   afu_rx;
    t_if_tx   afu_tx;
    logic     afu_credit_return;
    t_exec_op exec_op;
    t_rd_rsp  rd_rsp;

    // Timing stages toward the host
    platform_shim #(
        .N_REG_STAGES (N_REG_STAGES)
    ) u_shim (
        .pClk              (pClk),
        .rst_n             (rst_n),
        .fiu_rx            (host_rx),
        .fiu_tx            (host_tx),
        .fiu_credit_return (host_credit_return),
        .afu_rx            (afu_rx),
        .afu_tx            (afu_tx),
        .afu_credit_return (afu_credit_return)
    );

    afu_rx_decode u_decode (
        .pClk  (pClk),
        .rst_n (rst_n),
        .rx    (afu_rx),
        .op    (exec_op)
    );

    afu_csr_exec u_exec (
        .pClk  (pClk),
        .rst_n (rst_n),
        .op    (exec_op),
        .rsp   (rd_rsp)
    );

    // Credit counter lives here, on the AFU side of the shim
    afu_tx_result #(
        .TX_CREDITS (TX_CREDITS),
        .RSP_DEPTH  (RSP_DEPTH)
    ) u_result (
        .pClk          (pClk),
        .rst_n         (rst_n),
        .rsp           (rd_rsp),
        .credit_return (afu_credit_return),
        .tx            (afu_tx)
    );

endmodule

//--- verif/afu_tb.sv
/*
 * Testbench for afu_top with default parameters, single clock pClk.
 * Host drives and samples on the falling edge.
 * Expected reads come from a shadow CSR model, updated in issue order.
 * Host keeps at most RSP_DEPTH reads outstanding, as the protocol requires.
 */

module afu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ccip_shim_pkg::*;

    localparam int N_REG_STAGES = 1;
    localparam int TX_CREDITS   = 4;
    localparam int RSP_DEPTH    = 4;
    localparam int MAX_CYCLES   = 2000;
    localparam int DRAIN_LIMIT  = 200;

    // One expected MMIO read response
    typedef struct packed {
        logic [TID_W-1:0]  tid;
        logic [DATA_W-1:0] data;
    } t_exp;

    logic   pClk = 1'b0;
    logic   rst_n;
    t_if_rx host_rx;
    t_if_tx host_tx;
    logic   host_credit_return = 1'b0;

    integer            seed = 32'h0abf_05e7;
    t_exp              exp_q [$];
    t_exp              exp_e;
    logic [DATA_W-1:0] shadow [8];
    logic [TID_W-1:0]  next_tid;
    logic              hold_credits = 1'b0;
    string             current_test;
    int                errors = 0;
    int                test_errors = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                rsp_count = 0;
    int                owed = 0;
    int                cycle_count = 0;

    afu_top #(
        .N_REG_STAGES (N_REG_STAGES),
        .TX_CREDITS   (TX_CREDITS),
        .RSP_DEPTH    (RSP_DEPTH)
    ) UUT (
        .pClk               (pClk),
        .rst_n              (rst_n),
        .host_rx            (host_rx),
        .host_tx            (host_tx),
        .host_credit_return (host_credit_return)
    );

    // 40 ns period
    always #20 pClk = ~pClk;

    // ==================================================
    // Shadow CSR model
    // ==================================================
    function automatic void model_write(input logic [CSR_IDX_W-1:0] idx,
                                        input logic [DATA_W-1:0] data);
        // Only 1, 2 and 4 to 7 take writes
        if (idx == 4'd1 || idx == 4'd2 || (idx >= 4'd4 && idx <= 4'd7))
            shadow[idx[2:0]] = data;
    endfunction

    function automatic void model_accum(input logic [DATA_W-1:0] data);
        shadow[2] = shadow[2] + data;
        shadow[3] = shadow[3] + 64'd1;
    endfunction

    function automatic logic [DATA_W-1:0] csr_model_read(input logic [CSR_IDX_W-1:0] idx);
        if (idx == 4'd0)
            return AFU_ID;
        else if (idx < 4'd8)
            return shadow[idx[2:0]];
        else
            return '0;
    endfunction

    function automatic logic [DATA_W-1:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    function automatic void count_error();
        errors++;
        test_errors++;
    endfunction

    // ==================================================
    // Host stimulus, called on a falling edge
    // ==================================================
    task automatic send_rx(input t_rx_kind kind, input t_rx_hdr_u hdr,
                           input logic [DATA_W-1:0] data);
        host_rx = '{valid: 1'b1, kind: kind, hdr: hdr, data: data};
        @(negedge pClk);
        host_rx.valid = 1'b0;
    endtask

    task automatic mmio_write(input logic [CSR_IDX_W-1:0] idx, input logic [DATA_W-1:0] data);
        t_rx_hdr_u hdr;
        hdr.mmio.tid     = '0;
        hdr.mmio.csr_idx = idx;
        model_write(idx, data);
        send_rx(RX_MMIO_WR, hdr, data);
    endtask

    task automatic mmio_read(input logic [CSR_IDX_W-1:0] idx);
        t_rx_hdr_u hdr;
        // Outstanding limit
        while (exp_q.size() >= RSP_DEPTH)
            @(negedge pClk);
        hdr.mmio.tid     = next_tid;
        hdr.mmio.csr_idx = idx;
        exp_q.push_back('{tid: next_tid, data: csr_model_read(idx)});
        next_tid = next_tid + 8'd1;
        send_rx(RX_MMIO_RD, hdr, '0);
    endtask

    task automatic mem_rsp(input logic [DATA_W-1:0] data, input logic [1:0] cl_num);
        t_rx_hdr_u hdr;
        hdr.mem_rsp.mdata  = MDATA_W'($random(seed));
        hdr.mem_rsp.cl_num = cl_num;
        // Multi-line responses are dropped by the AFU
        if (cl_num == 2'd0)
            model_accum(data);
        send_rx(RX_MEM_RSP, hdr, data);
    endtask

    function automatic void start_test(input string name);
        current_test = name;
        test_errors  = 0;
    endfunction

    // Wait for all responses and credits, then report the test
    task automatic finish_test();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || owed != 0) && waited < DRAIN_LIMIT)
        begin
            @(negedge pClk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            $display("ERROR %s: %0d read responses never arrived", current_test, exp_q.size());
            count_error();
            exp_q.delete();
        end
        repeat (4) @(negedge pClk);
        tests_run++;
        if (test_errors == 0)
            $display("test %-12s ok", current_test);
        else
        begin
            tests_failed++;
            $display("test %-12s %0d errors", current_test, test_errors);
        end
    endtask

    // ==================================================
    // Host credit return and response checking
    // ==================================================
    always @(negedge pClk)
    begin
        if (rst_n)
        begin
            if (host_tx.valid)
                owed++;
            // One pulse per freed slot
            if (!hold_credits && owed > 0)
            begin
                host_credit_return = 1'b1;
                owed--;
            end
            else
                host_credit_return = 1'b0;
        end
    end

    always @(negedge pClk)
    begin
        if (rst_n && host_tx.valid)
        begin
            rsp_count++;
            if (exp_q.size() == 0)
            begin
                $display("ERROR %s: response with tid %0d arrived with no read outstanding",
                         current_test, host_tx.tid);
                count_error();
            end
            else
            begin
                exp_e = exp_q.pop_front();
                if (host_tx.tid != exp_e.tid)
                begin
                    $display("FAIL %s: tid expected %0d actual %0d",
                             current_test, exp_e.tid, host_tx.tid);
                    count_error();
                end
                if (host_tx.data != exp_e.data)
                begin
                    $display("FAIL %s: data for tid %0d expected %h actual %h",
                             current_test, exp_e.tid, exp_e.data, host_tx.data);
                    count_error();
                end
            end
        end
    end

    // Run limit
    always @(posedge pClk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("ERROR run stopped after %0d cycles without finishing", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial
    begin
        int                   lat;
        int                   mark;
        logic [31:0]          r;
        logic [CSR_IDX_W-1:0] idx;
        host_rx  = '0;
        rst_n    = 1'b0;
        next_tid = '0;
        foreach (shadow[i])
            shadow[i] = '0;
        repeat (4) @(posedge pClk);
        @(negedge pClk);
        rst_n = 1'b1;

        // Idle transmit, then AFU_ID read with fixed latency
        start_test("reset_id");
        repeat (8)
        begin
            @(negedge pClk);
            if (host_tx.valid)
            begin
                $display("ERROR reset_id: host_tx valid high with no read issued");
                count_error();
            end
        end
        mmio_read(4'd0);
        lat = 1;
        while (!host_tx.valid && lat < 20)
        begin
            @(negedge pClk);
            lat++;
        end
        if (lat != 2 * N_REG_STAGES + 3)
        begin
            $display("FAIL reset_id: read latency expected %0d actual %0d",
                     2 * N_REG_STAGES + 3, lat);
            count_error();
        end
        finish_test();

        // Scratch writes, ignored writes, full index sweep
        start_test("csr_rw");
        mmio_write(4'd1, rand_word());
        for (int i = 4; i < 8; i++)
            mmio_write(CSR_IDX_W'(i), rand_word());
        mmio_write(4'd0, rand_word());
        mmio_write(4'd3, rand_word());
        mmio_write(4'd8, rand_word());
        mmio_write(4'd13, rand_word());
        for (int i = 0; i < 16; i++)
            mmio_read(CSR_IDX_W'(i));
        finish_test();

        // 20 single-line responses, 2 multi-line dropped
        start_test("mem_accum");
        for (int i = 0; i < 22; i++)
        begin
            if (i == 7)
                mem_rsp(rand_word(), 2'd1);
            else if (i == 15)
                mem_rsp(rand_word(), 2'd3);
            else
                mem_rsp(rand_word(), 2'd0);
        end
        mmio_read(4'd2);
        mmio_read(4'd3);
        finish_test();

        // First 4 reads use all credits, next 4 wait in the queue
        start_test("backpressure");
        hold_credits = 1'b1;
        mark = rsp_count;
        for (int i = 0; i < 8; i++)
            mmio_read(CSR_IDX_W'(i));
        repeat (30) @(negedge pClk);
        if (rsp_count - mark != TX_CREDITS)
        begin
            $display("FAIL backpressure: responses without credit return expected %0d actual %0d",
                     TX_CREDITS, rsp_count - mark);
            count_error();
        end
        hold_credits = 1'b0;
        finish_test();

        // Accumulator preset by write
        start_test("accum_set");
        mmio_write(4'd2, rand_word());
        mmio_read(4'd2);
        for (int i = 0; i < 5; i++)
            mem_rsp(rand_word(), 2'd0);
        mmio_read(4'd2);
        mmio_read(4'd3);
        finish_test();

        start_test("mixed");
        for (int i = 0; i < 120; i++)
        begin
            r   = $random(seed);
            idx = r[7:4];
            case (r[1:0])
                2'd0:    mmio_write(idx, rand_word());
                2'd1:    mmio_read(idx);
                2'd2:    mem_rsp(rand_word(), r[8] ? 2'd0 : r[10:9]);
                default: @(negedge pClk);
            endcase
        end
        finish_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- files.f
design/ccip_shim_pkg.sv
design/platform_shim.sv
design/afu_rx_decode.sv
design/afu_csr_exec.sv
design/afu_tx_result.sv
design/afu_top.sv
verif/afu_tb.sv

//--- Makefile
# Verilator build for the AFU testbench

VERILATOR  ?= verilator
TOP        := afu_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Result is decided by the pass message in the simulator output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
